// ==== hdl/audio_soc_pkg.sv ====
package audio_soc_pkg;

  // Request from the bus master with a single-cycle stb pulse
  typedef struct packed {
    logic        stb;
    logic        we;
    logic [15:0] adr;   // Byte address
    logic [31:0] wdata;
  } bus_req_t;

  // Response with ack and rdata one cycle after stb
  typedef struct packed {
    logic        ack;
    logic [31:0] rdata;
  } bus_rsp_t;

  typedef enum logic [1:0] {
    SLV_NONE,
    SLV_RESET,
    SLV_AUDIO
  } slave_e;

  typedef enum logic [1:0] {
    RST_POR,  // Power-on sequence
    RST_RUN,
    RST_NDM   // Software-requested reset
  } rst_state_e;

  typedef logic signed [15:0] pcm_t;

  // Word offset inside a register block, bits 3:0 of the byte address
  typedef logic [3:0] reg_ofs_t;

  // Address map
  localparam logic [15:0] RESET_BASE = 16'h0030;
  localparam logic [15:0] RESET_SIZE = 16'h0008;
  localparam logic [15:0] AUDIO_BASE = 16'h1000;
  localparam logic [15:0] AUDIO_SIZE = 16'h0400;

  // Reset controller registers
  localparam reg_ofs_t REG_RST_CTRL   = 4'h0;  // Bit 0 sw reset, bit 1 por_done
  localparam reg_ofs_t REG_RST_REASON = 4'h4;  // Bit 0 power-on, bit 2 software

  // Audio registers
  localparam reg_ofs_t REG_PCM          = 4'h0;
  localparam reg_ofs_t REG_AUDIO_CTRL   = 4'h4;  // Bit 0 gain, bit 1 shutdown_n, bit 2 clear
  localparam reg_ofs_t REG_AUDIO_STATUS = 4'h8;  // Sticky acc1/acc2 overflow

endpackage

// ==== hdl/bus_decoder.sv ====
module bus_decoder (
  input  logic                    sys_clk,
  input  logic                    arst_n_i,
  input  audio_soc_pkg::bus_req_t bus_i,
  output audio_soc_pkg::bus_rsp_t bus_o,
  output logic                    rst_stb_o,
  output logic                    audio_stb_o,
  input  logic [31:0]             rst_rdata_i,
  input  logic [31:0]             audio_rdata_i
);

  audio_soc_pkg::slave_e sel;
  audio_soc_pkg::slave_e sel_q;
  logic                  ack_q;
  logic [31:0]           rdata_q;

  // One-level base/size compare
  always_comb begin
    sel = audio_soc_pkg::SLV_NONE;
    if (bus_i.adr >= audio_soc_pkg::RESET_BASE &&
        bus_i.adr < audio_soc_pkg::RESET_BASE + audio_soc_pkg::RESET_SIZE) begin
      sel = audio_soc_pkg::SLV_RESET;
    end else if (bus_i.adr >= audio_soc_pkg::AUDIO_BASE &&
                 bus_i.adr < audio_soc_pkg::AUDIO_BASE + audio_soc_pkg::AUDIO_SIZE) begin
      sel = audio_soc_pkg::SLV_AUDIO;
    end
  end

  assign rst_stb_o   = bus_i.stb && (sel == audio_soc_pkg::SLV_RESET);
  assign audio_stb_o = bus_i.stb && (sel == audio_soc_pkg::SLV_AUDIO);

  always_ff @(posedge sys_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q   <= 1'b0;
      sel_q   <= audio_soc_pkg::SLV_NONE;
      rdata_q <= '0;
    end else begin
      ack_q <= bus_i.stb;        // Fixed one-cycle latency
      if (bus_i.stb) begin
        sel_q   <= sel;
        // Slave data is only valid while the address is on the bus
        rdata_q <= (sel == audio_soc_pkg::SLV_RESET) ? rst_rdata_i : audio_rdata_i;
      end
    end
  end

  assign bus_o.ack = ack_q;
  // Unmapped accesses return zero
  assign bus_o.rdata = (ack_q && sel_q != audio_soc_pkg::SLV_NONE) ? rdata_q : '0;

endmodule

// ==== hdl/reset_ctrl.sv ====
module reset_ctrl #(
  parameter int POR_CYCLES       = 16,
  parameter int NDM_RESET_CYCLES = 8
) (
  input  logic                    sys_clk,
  input  logic                    arst_n_i,
  input  logic                    stb_i,
  input  logic                    we_i,
  input  audio_soc_pkg::reg_ofs_t adr_i,
  input  logic [31:0]             wdata_i,
  output logic [31:0]             rdata_o,
  output logic                    ndm_reset_o,
  output logic                    por_done_o
);

  localparam int MAX_CYCLES = (POR_CYCLES > NDM_RESET_CYCLES) ? POR_CYCLES : NDM_RESET_CYCLES;
  localparam int CNT_W      = $clog2(MAX_CYCLES + 1);

  logic [1:0]                 sync_q;  // Release synchroniser
  audio_soc_pkg::rst_state_e  state_q;
  logic [CNT_W-1:0]           cnt_q;
  logic                       ndm_q;
  logic                       por_done_q;
  logic                       por_flag_q;
  logic                       sw_flag_q;
  logic                       ctrl_wr;
  logic                       reason_wr;
  logic                       sw_req;

  assign ctrl_wr   = stb_i && we_i && (adr_i == audio_soc_pkg::REG_RST_CTRL);
  assign reason_wr = stb_i && we_i && (adr_i == audio_soc_pkg::REG_RST_REASON);
  assign sw_req    = ctrl_wr && wdata_i[0] && (state_q == audio_soc_pkg::RST_RUN);

  always_ff @(posedge sys_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  always_ff @(posedge sys_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= audio_soc_pkg::RST_POR;
      cnt_q      <= CNT_W'(POR_CYCLES - 1);
      ndm_q      <= 1'b1;
      por_done_q <= 1'b0;
    end else begin
      case (state_q)
        audio_soc_pkg::RST_POR: begin
          if (sync_q[1]) begin   // Count only after synchronised release
            if (cnt_q == '0) begin
              state_q    <= audio_soc_pkg::RST_RUN;
              ndm_q      <= 1'b0;
              por_done_q <= 1'b1;
            end else begin
              cnt_q <= cnt_q - 1'b1;
            end
          end
        end
        audio_soc_pkg::RST_RUN: begin
          if (sw_req) begin
            state_q <= audio_soc_pkg::RST_NDM;
            cnt_q   <= CNT_W'(NDM_RESET_CYCLES - 1);
            ndm_q   <= 1'b1;
          end
        end
        audio_soc_pkg::RST_NDM: begin
          if (cnt_q == '0) begin
            state_q <= audio_soc_pkg::RST_RUN;
            ndm_q   <= 1'b0;
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        default: state_q <= audio_soc_pkg::RST_POR;
      endcase
    end
  end

  // Sticky write-1-to-clear reason flags
  always_ff @(posedge sys_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      por_flag_q <= 1'b1;
      sw_flag_q  <= 1'b0;
    end else begin
      if (reason_wr && wdata_i[0]) begin
        por_flag_q <= 1'b0;
      end
      if (sw_req) begin
        sw_flag_q <= 1'b1;
      end else if (reason_wr && wdata_i[2]) begin
        sw_flag_q <= 1'b0;
      end
    end
  end

  always_comb begin
    case (adr_i)
      audio_soc_pkg::REG_RST_CTRL:
        rdata_o = {30'b0, por_done_q, state_q == audio_soc_pkg::RST_NDM};
      audio_soc_pkg::REG_RST_REASON:
        rdata_o = {29'b0, sw_flag_q, 1'b0, por_flag_q};
      default: rdata_o = '0;
    endcase
  end

  assign ndm_reset_o = ndm_q;
  assign por_done_o  = por_done_q;

endmodule

// ==== hdl/audio_regs.sv ====
module audio_regs (
  input  logic                    sys_clk,
  input  logic                    ndm_reset_i,
  input  logic                    stb_i,
  input  logic                    we_i,
  input  audio_soc_pkg::reg_ofs_t adr_i,
  input  logic [31:0]             wdata_i,
  output logic [31:0]             rdata_o,
  output audio_soc_pkg::pcm_t     pcm_o,
  input  logic                    acc1_ovf_i,
  input  logic                    acc2_ovf_i,
  output logic                    audio_gain_o,
  output logic                    audio_shutdown_n_o
);

  audio_soc_pkg::pcm_t pcm_q;
  logic                gain_q;
  logic                shdn_n_q;
  logic                ovf1_q;
  logic                ovf2_q;
  logic                pcm_wr;
  logic                ctrl_wr;
  logic                ovf_clr;

  assign pcm_wr  = stb_i && we_i && (adr_i == audio_soc_pkg::REG_PCM);
  assign ctrl_wr = stb_i && we_i && (adr_i == audio_soc_pkg::REG_AUDIO_CTRL);
  assign ovf_clr = ctrl_wr && wdata_i[2];

  always_ff @(posedge sys_clk or posedge ndm_reset_i) begin
    if (ndm_reset_i) begin
      pcm_q    <= '0;
      gain_q   <= 1'b0;
      shdn_n_q <= 1'b0;   // Amplifier off until software enables it
      ovf1_q   <= 1'b0;
      ovf2_q   <= 1'b0;
    end else begin
      if (pcm_wr) begin
        pcm_q <= audio_soc_pkg::pcm_t'(wdata_i[15:0]);
      end
      if (ctrl_wr) begin
        gain_q   <= wdata_i[0];
        shdn_n_q <= wdata_i[1];
      end
      // Clear beats a same-cycle overflow pulse
      if (ovf_clr) begin
        ovf1_q <= 1'b0;
        ovf2_q <= 1'b0;
      end else begin
        ovf1_q <= ovf1_q | acc1_ovf_i;
        ovf2_q <= ovf2_q | acc2_ovf_i;
      end
    end
  end

  always_comb begin
    case (adr_i)
      audio_soc_pkg::REG_PCM:          rdata_o = {16'b0, pcm_q};
      audio_soc_pkg::REG_AUDIO_CTRL:   rdata_o = {30'b0, shdn_n_q, gain_q};
      audio_soc_pkg::REG_AUDIO_STATUS: rdata_o = {30'b0, ovf2_q, ovf1_q};
      default:                         rdata_o = '0;
    endcase
  end

  assign pcm_o              = pcm_q;
  assign audio_gain_o       = gain_q;
  assign audio_shutdown_n_o = shdn_n_q;

endmodule

// ==== hdl/one_bit_dac.sv ====
module one_bit_dac #(
  parameter int DAC_CLK_DIV = 4
) (
  input  logic                sys_clk,
  input  logic                ndm_reset_i,
  input  audio_soc_pkg::pcm_t pcm_i,
  output logic                audio_out_o,
  output logic                acc1_ovf_o,
  output logic                acc2_ovf_o
);

  localparam int DIV_W = $clog2(DAC_CLK_DIV + 1);
  localparam int ACC_W = 20;  // Headroom of 16x full scale

  localparam logic signed [ACC_W-1:0] FS_POS = 32767;
  localparam logic signed [ACC_W-1:0] FS_NEG = -32768;

  logic [DIV_W-1:0]        div_q;
  logic                    clk_en;
  logic signed [ACC_W-1:0] acc1_q;
  logic signed [ACC_W-1:0] acc2_q;
  logic signed [ACC_W-1:0] acc1_n;
  logic signed [ACC_W-1:0] fb;
  logic signed [ACC_W:0]   sum1;
  logic signed [ACC_W:0]   sum2;
  logic                    out_q;
  logic                    ovf1_q;
  logic                    ovf2_q;

  assign clk_en = (div_q == '0);

  always_ff @(posedge sys_clk or posedge ndm_reset_i) begin
    if (ndm_reset_i) begin
      div_q <= '0;
    end else if (clk_en) begin
      div_q <= DIV_W'(DAC_CLK_DIV - 1);
    end else begin
      div_q <= div_q - 1'b1;
    end
  end

  // Full-scale feedback from the previous output bit
  assign fb = out_q ? FS_POS : FS_NEG;

  // One extra bit to see the wrap
  assign sum1   = acc1_q + pcm_i - fb;
  assign acc1_n = sum1[ACC_W-1:0];
  assign sum2   = acc2_q + acc1_n - fb;

  always_ff @(posedge sys_clk or posedge ndm_reset_i) begin
    if (ndm_reset_i) begin
      acc1_q <= '0;
      acc2_q <= '0;
      out_q  <= 1'b0;
      ovf1_q <= 1'b0;
      ovf2_q <= 1'b0;
    end else begin
      ovf1_q <= 1'b0;
      ovf2_q <= 1'b0;
      if (clk_en) begin
        acc1_q <= acc1_n;
        acc2_q <= sum2[ACC_W-1:0];
        out_q  <= ~sum2[ACC_W-1];          // 1 when acc2 is non-negative
        ovf1_q <= sum1[ACC_W] != sum1[ACC_W-1];
        ovf2_q <= sum2[ACC_W] != sum2[ACC_W-1];
      end
    end
  end

  assign audio_out_o = out_q;
  assign acc1_ovf_o  = ovf1_q;
  assign acc2_ovf_o  = ovf2_q;

endmodule

// ==== hdl/audio_soc_top.sv ====
module audio_soc_top #(
  parameter int POR_CYCLES       = 16,
  parameter int NDM_RESET_CYCLES = 8,
  parameter int DAC_CLK_DIV      = 4
) (
  input  logic                    sys_clk,
  input  logic                    arst_n_i,
  input  audio_soc_pkg::bus_req_t bus_i,
  output audio_soc_pkg::bus_rsp_t bus_o,
  output logic                    audio_out_o,
  output logic                    audio_gain_o,
  output logic                    audio_shutdown_n_o
);

  logic                rst_stb;
  logic                audio_stb;
  logic [31:0]         rst_rdata;
  logic [31:0]         audio_rdata;
  logic                ndm_reset;   // Resets the audio path only
  logic                por_done;
  logic                acc1_ovf;
  logic                acc2_ovf;
  audio_soc_pkg::pcm_t pcm;

  bus_decoder u_bus_decoder (
    .sys_clk       (sys_clk),
    .arst_n_i      (arst_n_i),
    .bus_i         (bus_i),
    .bus_o         (bus_o),
    .rst_stb_o     (rst_stb),
    .audio_stb_o   (audio_stb),
    .rst_rdata_i   (rst_rdata),
    .audio_rdata_i (audio_rdata)
  );

  reset_ctrl #(
    .POR_CYCLES       (POR_CYCLES),
    .NDM_RESET_CYCLES (NDM_RESET_CYCLES)
  ) u_reset_ctrl (
    .sys_clk     (sys_clk),
    .arst_n_i    (arst_n_i),
    .stb_i       (rst_stb),
    .we_i        (bus_i.we),
    .adr_i       (bus_i.adr[3:0]),
    .wdata_i     (bus_i.wdata),
    .rdata_o     (rst_rdata),
    .ndm_reset_o (ndm_reset),
    .por_done_o  (por_done)
  );

  audio_regs u_audio_regs (
    .sys_clk            (sys_clk),
    .ndm_reset_i        (ndm_reset),
    .stb_i              (audio_stb),
    .we_i               (bus_i.we),
    .adr_i              (bus_i.adr[3:0]),
    .wdata_i            (bus_i.wdata),
    .rdata_o            (audio_rdata),
    .pcm_o              (pcm),
    .acc1_ovf_i         (acc1_ovf),
    .acc2_ovf_i         (acc2_ovf),
    .audio_gain_o       (audio_gain_o),
    .audio_shutdown_n_o (audio_shutdown_n_o)
  );

  one_bit_dac #(
    .DAC_CLK_DIV (DAC_CLK_DIV)
  ) u_one_bit_dac (
    .sys_clk     (sys_clk),
    .ndm_reset_i (ndm_reset),
    .pcm_i       (pcm),
    .audio_out_o (audio_out_o),
    .acc1_ovf_o  (acc1_ovf),
    .acc2_ovf_o  (acc2_ovf)
  );

endmodule

// ==== dv/audio_soc_asserts.sv ====
module tb_audio_soc_asserts (
  input logic sys_clk,
  input logic arst_n_i,
  input logic stb_i,
  input logic ack_i,
  input logic ndm_reset_i,
  input logic por_done_i,
  input logic shutdown_n_i,
  input logic audio_out_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // Ack exactly one cycle after each strobe
  a_ack_follows_stb: assert property (@(posedge sys_clk) disable iff (!arst_n_i)
    stb_i |=> ack_i)
    else $error("acknowledge missing one cycle after strobe");

  a_no_stray_ack: assert property (@(posedge sys_clk) disable iff (!arst_n_i)
    !stb_i |=> !ack_i)
    else $error("acknowledge without a strobe");

  // Amplifier and DAC output held low during the audio reset
  a_audio_quiet: assert property (@(posedge sys_clk) disable iff (!arst_n_i)
    ndm_reset_i |-> !shutdown_n_i && !audio_out_i)
    else $error("audio outputs active while ndm_reset is high");

  a_ndm_release: assert property (@(posedge sys_clk) disable iff (!arst_n_i)
    $fell(ndm_reset_i) |-> por_done_i)
    else $error("ndm_reset released before power-on sequence finished");

endmodule

bind audio_soc_top tb_audio_soc_asserts u_asserts (
  .sys_clk      (sys_clk),
  .arst_n_i     (arst_n_i),
  .stb_i        (bus_i.stb),
  .ack_i        (bus_o.ack),
  .ndm_reset_i  (ndm_reset),
  .por_done_i   (por_done),
  .shutdown_n_i (audio_shutdown_n_o),
  .audio_out_i  (audio_out_o)
);

// ==== dv/tb_audio_soc.sv ====
module tb_audio_soc;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int DAC_DIV = 4;
  localparam int N_STEPS = 38;
  localparam int N_DAC   = 8;
  // Bus steps plus settling and measurement windows of every DAC step
  localparam int LIMIT   = N_STEPS * 200 + N_DAC * (64 + 2048 + 20) * DAC_DIV;

  typedef enum logic [2:0] {
    OP_WR,
    OP_RD,
    OP_POLL,  // Read until the masked data matches
    OP_PIN,   // Check {shutdown_n, gain} pins
    OP_DAC,   // Density check with wdata[15:0] as sample
    OP_RND    // Density check with an LFSR sample
  } op_e;

  typedef struct packed {
    op_e         op;
    logic [15:0] adr;
    logic [31:0] wdata;
    logic [31:0] rdata_exp;
    logic [31:0] mask;
  } step_t;

  logic                    sys_clk;
  logic                    arst_n_i;
  audio_soc_pkg::bus_req_t bus_i;
  audio_soc_pkg::bus_rsp_t bus_o;
  logic                    audio_out_o;
  logic                    audio_gain_o;
  logic                    audio_shutdown_n_o;
  logic [15:0]             lfsr_q;
  int unsigned             cycles = 0;

  step_t steps [N_STEPS] = '{
    '{OP_POLL, 16'h0030, 32'h0, 32'h2, 32'h2},  // Wait for por_done
    '{OP_RD,   16'h0034, 32'h0, 32'h1, 32'hFFFF_FFFF},
    '{OP_RD,   16'h1000, 32'h0, 32'h0, 32'hFFFF_FFFF},
    '{OP_RD,   16'h1004, 32'h0, 32'h0, 32'hFFFF_FFFF},
    '{OP_RD,   16'h1008, 32'h0, 32'h0, 32'hFFFF_FFFF},
    '{OP_PIN,  16'h0000, 32'h0, 32'h0, 32'hFFFF_FFFF},
    '{OP_WR,   16'h1000, 32'hABCD_1234, 32'h0, 32'h0},
    '{OP_RD,   16'h1000, 32'h0, 32'h1234, 32'hFFFF_FFFF},
    '{OP_WR,   16'h1004, 32'hFFFF_FFFF, 32'h0, 32'h0},
    '{OP_RD,   16'h1004, 32'h0, 32'h3, 32'hFFFF_FFFF},
    '{OP_PIN,  16'h0000, 32'h0, 32'h3, 32'hFFFF_FFFF},
    '{OP_WR,   16'h1004, 32'h1, 32'h0, 32'h0},
    '{OP_PIN,  16'h0000, 32'h0, 32'h1, 32'hFFFF_FFFF},
    '{OP_WR,   16'h1004, 32'h2, 32'h0, 32'h0},
    '{OP_RD,   16'h1004, 32'h0, 32'h2, 32'hFFFF_FFFF},
    '{OP_PIN,  16'h0000, 32'h0, 32'h2, 32'hFFFF_FFFF},
    '{OP_RD,   16'h2000, 32'h0, 32'h0, 32'hFFFF_FFFF},  // Unmapped
    '{OP_WR,   16'h2000, 32'hFFFF_FFFF, 32'h0, 32'h0},
    '{OP_RD,   16'h1000, 32'h0, 32'h1234, 32'hFFFF_FFFF},
    '{OP_RD,   16'h1004, 32'h0, 32'h2, 32'hFFFF_FFFF},
    '{OP_RD,   16'h0034, 32'h0, 32'h1, 32'hFFFF_FFFF},
    '{OP_WR,   16'h0030, 32'h1, 32'h0, 32'h0},          // Software reset
    '{OP_POLL, 16'h0030, 32'h0, 32'h0, 32'h1},
    '{OP_RD,   16'h1000, 32'h0, 32'h0, 32'hFFFF_FFFF},
    '{OP_RD,   16'h1004, 32'h0, 32'h0, 32'hFFFF_FFFF},
    '{OP_RD,   16'h1008, 32'h0, 32'h0, 32'hFFFF_FFFF},
    '{OP_PIN,  16'h0000, 32'h0, 32'h0, 32'hFFFF_FFFF},
    '{OP_RD,   16'h0034, 32'h0, 32'h5, 32'hFFFF_FFFF},
    '{OP_WR,   16'h0034, 32'h5, 32'h0, 32'h0},
    '{OP_RD,   16'h0034, 32'h0, 32'h0, 32'hFFFF_FFFF},
    '{OP_DAC,  16'h0000, 32'h0000, 32'h0, 32'h0},
    '{OP_DAC,  16'h0000, 32'h2000, 32'h0, 32'h0},       // 8192
    '{OP_DAC,  16'h0000, 32'hE000, 32'h0, 32'h0},       // -8192
    '{OP_DAC,  16'h0000, 32'h3E80, 32'h0, 32'h0},       // 16000
    '{OP_RND,  16'h0000, 32'h0, 32'h0, 32'h0},
    '{OP_RND,  16'h0000, 32'h0, 32'h0, 32'h0},
    '{OP_RND,  16'h0000, 32'h0, 32'h0, 32'h0},
    '{OP_RND,  16'h0000, 32'h0, 32'h0, 32'h0}
  };

  audio_soc_top #(
    .POR_CYCLES       (16),
    .NDM_RESET_CYCLES (8),
    .DAC_CLK_DIV      (DAC_DIV)
  ) dut (
    .sys_clk            (sys_clk),
    .arst_n_i           (arst_n_i),
    .bus_i              (bus_i),
    .bus_o              (bus_o),
    .audio_out_o        (audio_out_o),
    .audio_gain_o       (audio_gain_o),
    .audio_shutdown_n_o (audio_shutdown_n_o)
  );

  initial begin
    sys_clk = 1'b0;
    forever #10 sys_clk = ~sys_clk;
  end

  task automatic stop_with_fail();
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation aborted");
  endtask

  task automatic expect_equal(input string what, input logic [31:0] got,
                              input logic [31:0] want);
    assert (got === want) else begin
      $display("Error at %0t ns: %s, got 0x%08h, expected 0x%08h", $time, what, got, want);
      stop_with_fail();
    end
  endtask

  // One strobe, ack must follow on the next edge
  task automatic bus_cycle(input logic we, input logic [15:0] adr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    @(negedge sys_clk);
    expect_equal("acknowledge before strobe", {31'b0, bus_o.ack}, 32'h0);
    bus_i.stb   = 1'b1;
    bus_i.we    = we;
    bus_i.adr   = adr;
    bus_i.wdata = wdata;
    @(negedge sys_clk);
    expect_equal("acknowledge after strobe", {31'b0, bus_o.ack}, 32'h1);
    rdata     = bus_o.rdata;
    bus_i.stb = 1'b0;
    bus_i.we  = 1'b0;
  endtask

  task automatic bus_write(input logic [15:0] adr, input logic [31:0] wdata);
    logic [31:0] unused;
    bus_cycle(1'b1, adr, wdata, unused);
  endtask

  task automatic bus_read(input logic [15:0] adr, output logic [31:0] rdata);
    bus_cycle(1'b0, adr, 32'h0, rdata);
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic next_random_pcm(output logic signed [15:0] v);
    logic [14:0] bits;
    bits = '0;
    for (int i = 0; i < 15; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      bits   = {bits[13:0], lfsr_q[0]};
    end
    v = $signed({1'b0, bits}) - 16'sd16384;  // Within +-16384
  endtask

  task automatic check_density(input logic signed [15:0] sample);
    int          ones;
    int          sval;
    real         frac;
    real         target;
    logic [31:0] rd;
    ones = 0;
    sval = sample;
    bus_write(audio_soc_pkg::AUDIO_BASE | 16'(audio_soc_pkg::REG_PCM), {16'b0, sample});
    repeat (64 * DAC_DIV) @(negedge sys_clk);
    for (int i = 0; i < 2048; i++) begin
      repeat (DAC_DIV) @(negedge sys_clk);
      ones += int'(audio_out_o);
    end
    frac   = real'(ones) / 2048.0;
    target = (real'(sval) + 32768.0) / 65536.0;
    assert (frac - target <= 0.02 && target - frac <= 0.02) else begin
      $display("Error at %0t ns: density %f for sample %0d, expected %f",
               $time, frac, sval, target);
      stop_with_fail();
    end
    bus_read(audio_soc_pkg::AUDIO_BASE | 16'(audio_soc_pkg::REG_AUDIO_STATUS), rd);
    expect_equal("overflow status", rd, 32'h0);
  endtask

  task automatic run_step(input step_t s);
    logic [31:0]        rd;
    logic signed [15:0] sample;
    case (s.op)
      OP_WR: bus_write(s.adr, s.wdata);
      OP_RD: begin
        bus_read(s.adr, rd);
        expect_equal($sformatf("read of 0x%04h", s.adr), rd & s.mask, s.rdata_exp);
      end
      OP_POLL: begin
        do begin
          bus_read(s.adr, rd);
        end while ((rd & s.mask) != s.rdata_exp);
      end
      OP_PIN: expect_equal("amplifier pins", {30'b0, audio_shutdown_n_o, audio_gain_o},
                           s.rdata_exp);
      OP_DAC: check_density(s.wdata[15:0]);
      default: begin
        next_random_pcm(sample);
        check_density(sample);
      end
    endcase
  endtask

  always @(posedge sys_clk) begin
    cycles <= cycles + 1;
    if (cycles > LIMIT) begin
      $display("Timeout: no result after %0d clock cycles", cycles);
      stop_with_fail();
    end
  end

  initial begin
    bus_i    = '0;
    arst_n_i = 1'b0;
    lfsr_q   = 16'd24;
    repeat (5) @(negedge sys_clk);
    arst_n_i = 1'b1;
    for (int i = 0; i < N_STEPS; i++) begin
      run_step(steps[i]);
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// ==== src.f ====
hdl/audio_soc_pkg.sv
hdl/bus_decoder.sv
hdl/reset_ctrl.sv
hdl/audio_regs.sv
hdl/one_bit_dac.sv
hdl/audio_soc_top.sv
dv/audio_soc_asserts.sv
dv/tb_audio_soc.sv

// ==== run.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_audio_soc -f src.f -o tb_audio_soc > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/tb_audio_soc > sim.log 2>&1
grep -q "TEST RESULT: FAIL" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "Simulation did not pass, see sim.log"; exit 1; }
echo "Simulation passed"
